// File: project.f
src/cache_tag_pkg.sv
src/tag_sram.sv
src/tag_way_array.sv
src/lru_tracker.sv
src/tag_check.sv
src/tag_req_port.sv
src/cache_tag_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_cache_tag_top.sv

// File: Bender.yml
package:
  name: cache_tag

sources:
  # Synthesizable cache tag subsystem, package first
  - target: any(rtl, simulation)
    files:
      - src/cache_tag_pkg.sv
      - src/tag_sram.sv
      - src/tag_way_array.sv
      - src/lru_tracker.sv
      - src/tag_check.sv
      - src/tag_req_port.sv
      - src/cache_tag_top.sv

  # Testbench with clock source, checker and top
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_checker.sv
      - verification/tb_cache_tag_top.sv

// File: verification/tb_cache_tag_top.sv
// Testbench top that runs directed and random four-phase lookups into the cache tag subsystem
`default_nettype none

module tb_cache_tag_top;

	localparam int NUM_REQUESTS = 400;
	localparam int CYCLES_PER_REQUEST = 12;
	localparam int CYCLE_LIMIT = NUM_REQUESTS * CYCLES_PER_REQUEST + 100;

	logic                        clk;
	logic                        reset;
	logic                        req;
	cache_tag_pkg::lookup_req_t  req_data;
	logic                        ack;
	cache_tag_pkg::lookup_resp_t resp;
	int                          value_errors;
	int                          protocol_errors;
	int                          checked;
	int                          issued = 0;
	int                          cycle_count = 0;

	tb_clock_gen #(
		.PERIOD(8),
		.RESET_CYCLES(3)
	) clock_inst (
		.clk_o(clk),
		.reset_o(reset)
	);

	cache_tag_top cache_tag_top_inst (
		.clk(clk),
		.reset(reset),
		.req_i(req),
		.req_data_i(req_data),
		.ack_o(ack),
		.resp_o(resp)
	);

	tb_checker checker_inst (
		.clk(clk),
		.reset(reset),
		.req_i(req),
		.req_data_i(req_data),
		.ack_i(ack),
		.resp_i(resp),
		.value_errors_o(value_errors),
		.protocol_errors_o(protocol_errors),
		.checked_o(checked)
	);

	// One full handshake with random idle time before it and random hold time after ack
	task automatic run_lookup(input logic is_store, input cache_tag_pkg::tag_t tag,
		input cache_tag_pkg::set_t set_idx);
		int idle;
		int hold;
		idle = $urandom_range(0, 2);
		hold = $urandom_range(0, 2);
		repeat (idle) @(posedge clk);
		@(posedge clk);
		req <= 1'b1;
		req_data.is_store <= is_store;
		req_data.addr <= {tag, set_idx};
		do
			@(negedge clk);
		while (!ack);
		repeat (hold) @(posedge clk);
		@(posedge clk);
		req <= 1'b0;
		do
			@(negedge clk);
		while (ack);
		issued++;
	endtask

	initial
	begin
		req = 1'b0;
		req_data = '0;
		void'($urandom(42));
		do
			@(posedge clk);
		while (reset);

		// Set 0 from reset misses four times, filling ways 0, 2, 1 and 3
		for (int i = 1; i <= 4; i++)
			run_lookup(1'b0, cache_tag_pkg::tag_t'(i), 4'h0);
		run_lookup(1'b0, 8'h02, 4'h0);
		run_lookup(1'b1, 8'h03, 4'h0);

		// Four new tags evict every old line, one of them dirty
		for (int i = 0; i < 4; i++)
			run_lookup(1'b0, cache_tag_pkg::tag_t'(8'h10 + i), 4'h0);

		// Six tags over three sets keep hits, clean and dirty evictions mixed
		for (int i = 0; i < NUM_REQUESTS - 10; i++)
			run_lookup(1'($urandom_range(0, 1)), cache_tag_pkg::tag_t'(8'h20 + $urandom_range(0, 5)),
				cache_tag_pkg::set_t'($urandom_range(4, 6)));

		repeat (4) @(posedge clk);
		if (checked != NUM_REQUESTS)
			$display("Only %0d of %0d responses were checked", checked, NUM_REQUESTS);
		$display("Summary: %0d value errors, %0d protocol errors, %0d responses checked",
			value_errors, protocol_errors, checked);
		if (value_errors == 0 && protocol_errors == 0 && checked == NUM_REQUESTS)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with %0d of %0d requests done",
				cycle_count, issued, NUM_REQUESTS);
			$display("Checks failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
// Testbench monitor that models tags, dirty bits and tree LRU and checks every response and handshake
`default_nettype none

module tb_checker (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        req_i,
	input  wire cache_tag_pkg::lookup_req_t  req_data_i,
	input  wire logic                        ack_i,
	input  wire cache_tag_pkg::lookup_resp_t resp_i,
	output int                               value_errors_o,
	output int                               protocol_errors_o,
	output int                               checked_o
);

	typedef enum {
		WAIT_REQ,
		WAIT_ACK,
		HOLD,
		RELEASE
	} phase_t;

	logic [cache_tag_pkg::NUM_WAYS-1:0] model_valid [cache_tag_pkg::NUM_SETS];
	logic [cache_tag_pkg::NUM_WAYS-1:0] model_dirty [cache_tag_pkg::NUM_SETS];
	cache_tag_pkg::tag_t                model_tag [cache_tag_pkg::NUM_SETS][cache_tag_pkg::NUM_WAYS];
	logic [cache_tag_pkg::LRU_BITS-1:0] model_tree [cache_tag_pkg::NUM_SETS];

	phase_t                      phase;
	cache_tag_pkg::lookup_req_t  cur_req;
	cache_tag_pkg::lookup_resp_t held_resp;
	int                          cycle = 0;
	int                          req_edge;
	int                          fall_edge;

	// Counts rising edges, read only on falling edges where it is stable
	always @(posedge clk)
		cycle <= cycle + 1;

	// Expected response from the model state before this lookup
	function automatic cache_tag_pkg::lookup_resp_t expected_response(
		cache_tag_pkg::lookup_req_t req);
		cache_tag_pkg::lookup_resp_t resp;
		cache_tag_pkg::tag_t         tag;
		cache_tag_pkg::way_t         victim;
		int                          set_idx;
		tag = req.addr[cache_tag_pkg::ADDR_BITS-1:cache_tag_pkg::SET_BITS];
		set_idx = req.addr[cache_tag_pkg::SET_BITS-1:0];
		resp = '0;
		for (int w = 0; w < cache_tag_pkg::NUM_WAYS; w++)
		begin
			if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
			begin
				resp.hit = 1'b1;
				resp.way = cache_tag_pkg::way_t'(w);
			end
		end
		if (!resp.hit)
		begin
			// Root 0 points at ways 0 and 1, and a pair bit of 0 picks the lower way
			if (!model_tree[set_idx][0])
				victim = model_tree[set_idx][1] ? 2'd1 : 2'd0;
			else
				victim = model_tree[set_idx][2] ? 2'd3 : 2'd2;
			resp.way = victim;
			resp.evict_valid = model_valid[set_idx][victim];
			resp.evict_dirty = model_dirty[set_idx][victim];
			resp.evict_tag = model_tag[set_idx][victim];
		end
		return resp;
	endfunction

	task automatic apply_update(input cache_tag_pkg::lookup_req_t req,
		input cache_tag_pkg::lookup_resp_t resp);
		int                  set_idx;
		cache_tag_pkg::way_t way;
		set_idx = req.addr[cache_tag_pkg::SET_BITS-1:0];
		way = resp.way;
		if (!resp.hit)
		begin
			model_valid[set_idx][way] = 1'b1;
			model_tag[set_idx][way] = req.addr[cache_tag_pkg::ADDR_BITS-1:cache_tag_pkg::SET_BITS];
			model_dirty[set_idx][way] = req.is_store;
		end
		else if (req.is_store)
			model_dirty[set_idx][way] = 1'b1;
		// The root turns to the pair not used and the pair bit to the partner way
		model_tree[set_idx][0] = (way < 2);
		case (way)
			2'd0: model_tree[set_idx][1] = 1'b1;
			2'd1: model_tree[set_idx][1] = 1'b0;
			2'd2: model_tree[set_idx][2] = 1'b1;
			default: model_tree[set_idx][2] = 1'b0;
		endcase
	endtask

	task automatic compare_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Error: %s expected 0x%0h got 0x%0h", name, expected, actual);
			value_errors_o++;
		end
	endtask

	task automatic report_protocol(input string msg);
		$display("Protocol fault at cycle %0d: %s", cycle, msg);
		protocol_errors_o++;
	endtask

	task automatic check_response(input cache_tag_pkg::lookup_req_t req,
		input cache_tag_pkg::lookup_resp_t actual);
		cache_tag_pkg::lookup_resp_t expected;
		expected = expected_response(req);
		compare_field("resp_o.hit", expected.hit, actual.hit);
		compare_field("resp_o.way", expected.way, actual.way);
		// The evict fields only mean something on a miss
		if (!expected.hit)
		begin
			compare_field("resp_o.evict_valid", expected.evict_valid, actual.evict_valid);
			compare_field("resp_o.evict_dirty", expected.evict_dirty, actual.evict_dirty);
			compare_field("resp_o.evict_tag", expected.evict_tag, actual.evict_tag);
		end
		apply_update(req, expected);
		checked_o++;
	endtask

	always @(negedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < cache_tag_pkg::NUM_SETS; s++)
			begin
				model_valid[s] = '0;
				model_dirty[s] = '0;
				model_tree[s] = '0;
				for (int w = 0; w < cache_tag_pkg::NUM_WAYS; w++)
					model_tag[s][w] = '0;
			end
			phase = WAIT_REQ;
			value_errors_o = 0;
			protocol_errors_o = 0;
			checked_o = 0;
		end
		else
		begin
			case (phase)
				WAIT_REQ:
				begin
					if (ack_i)
						report_protocol("ack_o is high with no request pending");
					if (req_i)
					begin
						cur_req = req_data_i;
						req_edge = cycle + 1;
						phase = WAIT_ACK;
					end
				end
				WAIT_ACK:
				begin
					if (ack_i)
					begin
						if (cycle - req_edge != 3)
							report_protocol($sformatf("ack_o rose %0d cycles after req_i, not 3",
								cycle - req_edge));
						check_response(cur_req, resp_i);
						held_resp = resp_i;
						phase = HOLD;
					end
					else if (!req_i)
						report_protocol("req_i fell before ack_o rose");
				end
				HOLD:
				begin
					if (!ack_i)
						report_protocol("ack_o fell while req_i was still high");
					else if (resp_i !== held_resp)
						report_protocol("resp_o changed while ack_o was high");
					if (!req_i)
					begin
						fall_edge = cycle + 1;
						phase = RELEASE;
					end
				end
				default:
				begin
					if (req_i)
						report_protocol("req_i rose again before ack_o fell");
					if (!ack_i)
					begin
						if (cycle - fall_edge != 1)
							report_protocol($sformatf("ack_o fell %0d cycles after req_i, not 1",
								cycle - fall_edge));
						phase = WAIT_REQ;
					end
					else if (resp_i !== held_resp)
						report_protocol("resp_o changed before ack_o fell");
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// Clock and reset source for the testbench, with a set period and a reset held for whole cycles
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic reset_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD / 2) clk_o = ~clk_o;
	end

	// Reset is released on a rising edge after the given number of cycles
	initial
	begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: src/cache_tag_top.sv
// Top level of the cache tag subsystem, joining the request port, tag arrays, LRU and tag check
`default_nettype none

module cache_tag_top (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        req_i,
	input  wire cache_tag_pkg::lookup_req_t  req_data_i,
	output      logic                        ack_o,
	output      cache_tag_pkg::lookup_resp_t resp_o
);

	logic                                                   lookup_valid;
	cache_tag_pkg::lookup_req_t                             lookup;
	cache_tag_pkg::tag_entry_t [cache_tag_pkg::NUM_WAYS-1:0] entries;
	logic [cache_tag_pkg::NUM_WAYS-1:0]                     dirty;
	cache_tag_pkg::way_t                                    victim;
	logic                                                   resp_valid;
	cache_tag_pkg::lookup_resp_t                            resp;
	cache_tag_pkg::tag_write_t                              tag_write;
	cache_tag_pkg::lru_update_t                             lru_update;

	tag_req_port port_inst (
		.clk(clk),
		.reset(reset),
		.req_i(req_i),
		.req_data_i(req_data_i),
		.resp_valid_i(resp_valid),
		.resp_i(resp),
		.ack_o(ack_o),
		.resp_o(resp_o),
		.lookup_valid_o(lookup_valid),
		.lookup_o(lookup)
	);

	tag_way_array ways_inst (
		.clk(clk),
		.reset(reset),
		.rd_en_i(lookup_valid),
		.rd_set_i(cache_tag_pkg::addr_set(lookup.addr)),
		.write_i(tag_write),
		.entries_o(entries),
		.dirty_o(dirty)
	);

	lru_tracker lru_inst (
		.clk(clk),
		.reset(reset),
		.rd_en_i(lookup_valid),
		.rd_set_i(cache_tag_pkg::addr_set(lookup.addr)),
		.update_i(lru_update),
		.victim_o(victim)
	);

	tag_check check_inst (
		.clk(clk),
		.reset(reset),
		.lookup_valid_i(lookup_valid),
		.lookup_i(lookup),
		.entries_i(entries),
		.dirty_i(dirty),
		.victim_i(victim),
		.resp_valid_o(resp_valid),
		.resp_o(resp),
		.write_o(tag_write),
		.lru_o(lru_update)
	);

endmodule

`default_nettype wire

// File: src/tag_req_port.sv
// Four-phase req/ack front end that launches one lookup per handshake and holds its response
`default_nettype none

module tag_req_port (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        req_i,
	input  wire cache_tag_pkg::lookup_req_t  req_data_i,
	input  wire logic                        resp_valid_i,
	input  wire cache_tag_pkg::lookup_resp_t resp_i,
	output      logic                        ack_o,
	output      cache_tag_pkg::lookup_resp_t resp_o,
	output      logic                        lookup_valid_o,
	output      cache_tag_pkg::lookup_req_t  lookup_o
);

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		ACK
	} state_t;

	state_t state;
	logic   req_q;

	// req_i is registered once before the FSM acts on it
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			req_q <= 1'b0;
			ack_o <= 1'b0;
			lookup_valid_o <= 1'b0;
		end
		else
		begin
			req_q <= req_i;
			lookup_valid_o <= 1'b0;
			case (state)
				IDLE:
					if (req_q)
					begin
						lookup_valid_o <= 1'b1;
						state <= BUSY;
					end
				BUSY:
					if (resp_valid_i)
					begin
						ack_o <= 1'b1;
						state <= ACK;
					end
				ACK:
					if (!req_q)
					begin
						ack_o <= 1'b0;
						state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == IDLE && req_q)
			lookup_o <= req_data_i;
		if (state == BUSY && resp_valid_i)
			resp_o <= resp_i;
	end

	// The tag pipeline answers only the lookup this port launched
	a_resp_while_busy: assert property (@(posedge clk) disable iff (reset)
		resp_valid_i |-> state == BUSY)
		else $error("tag_req_port got a response with no lookup pending");

endmodule

`default_nettype wire

// File: src/tag_check.sv
// Hit detection and victim selection, producing the response and the tag, dirty and LRU updates
`default_nettype none

module tag_check (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       lookup_valid_i,
	input  wire cache_tag_pkg::lookup_req_t lookup_i,
	input  wire cache_tag_pkg::tag_entry_t [cache_tag_pkg::NUM_WAYS-1:0] entries_i,
	input  wire logic [cache_tag_pkg::NUM_WAYS-1:0]                       dirty_i,
	input  wire cache_tag_pkg::way_t        victim_i,
	output      logic                       resp_valid_o,
	output      cache_tag_pkg::lookup_resp_t resp_o,
	output      cache_tag_pkg::tag_write_t  write_o,
	output      cache_tag_pkg::lru_update_t lru_o
);

	logic                               req_valid_q;
	cache_tag_pkg::lookup_req_t         req_q;
	cache_tag_pkg::tag_t                req_tag;
	cache_tag_pkg::set_t                req_set;
	logic [cache_tag_pkg::NUM_WAYS-1:0] hit_mask;
	logic                               hit;
	cache_tag_pkg::way_t                hit_way;
	cache_tag_pkg::way_t                use_way;

	// The request is held one cycle so it lines up with the memory read data
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			req_valid_q <= 1'b0;
		else
			req_valid_q <= lookup_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (lookup_valid_i)
			req_q <= lookup_i;
	end

	assign req_tag = cache_tag_pkg::addr_tag(req_q.addr);
	assign req_set = cache_tag_pkg::addr_set(req_q.addr);

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < cache_tag_pkg::NUM_WAYS; w++)
		begin
			hit_mask[w] = entries_i[w].valid && entries_i[w].tag == req_tag;
			if (hit_mask[w])
				hit_way = cache_tag_pkg::way_t'(w);
		end
	end

	assign hit = |hit_mask;
	assign use_way = hit ? hit_way : victim_i;

	assign resp_valid_o = req_valid_q;
	assign resp_o.hit = hit;
	assign resp_o.way = use_way;
	assign resp_o.evict_valid = !hit && entries_i[victim_i].valid;
	assign resp_o.evict_dirty = !hit && dirty_i[victim_i];
	assign resp_o.evict_tag = hit ? '0 : entries_i[victim_i].tag;

	// A miss fills the victim, and the dirty bit follows the request type
	assign write_o.enable = req_valid_q && !hit;
	assign write_o.set = req_set;
	assign write_o.way = use_way;
	assign write_o.entry.valid = 1'b1;
	assign write_o.entry.tag = req_tag;
	assign write_o.dirty_enable = req_valid_q && (!hit || req_q.is_store);
	assign write_o.dirty_value = req_q.is_store;

	assign lru_o.enable = req_valid_q;
	assign lru_o.set = req_set;
	assign lru_o.way = use_way;

	// Fills only ever go to a way after a miss, so a tag lives in one way of a set
	a_single_hit: assert property (@(posedge clk) disable iff (reset)
		req_valid_q |-> $onehot0(hit_mask))
		else $error("tag_check found more than one matching way");

endmodule

`default_nettype wire

// File: src/lru_tracker.sv
// Tree pseudo-LRU state per set, giving a registered victim way and updated on every use
`default_nettype none

module lru_tracker (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       rd_en_i,
	input  wire cache_tag_pkg::set_t        rd_set_i,
	input  wire cache_tag_pkg::lru_update_t update_i,
	output      cache_tag_pkg::way_t        victim_o
);

	// Bit 0 is the root, bit 1 selects within ways 0-1, bit 2 within ways 2-3
	logic [cache_tag_pkg::LRU_BITS-1:0] tree [cache_tag_pkg::NUM_SETS];

	// Follow the pointers down to the least recently used way
	function automatic cache_tag_pkg::way_t pick_victim(logic [cache_tag_pkg::LRU_BITS-1:0] bits);
		if (bits[0])
			return {1'b1, bits[2]};
		else
			return {1'b0, bits[1]};
	endfunction

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < cache_tag_pkg::NUM_SETS; s++)
				tree[s] <= '0;
			victim_o <= '0;
		end
		else
		begin
			if (rd_en_i)
				victim_o <= pick_victim(tree[rd_set_i]);

			// Point the root at the other pair and the pair bit at the partner way
			if (update_i.enable)
			begin
				tree[update_i.set][0] <= !update_i.way[1];
				if (update_i.way[1])
					tree[update_i.set][2] <= !update_i.way[0];
				else
					tree[update_i.set][1] <= !update_i.way[0];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/tag_way_array.sv
// Tag and dirty memories of all ways, read in parallel for one set and written one way at a time
`default_nettype none

module tag_way_array (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic                      rd_en_i,
	input  wire cache_tag_pkg::set_t       rd_set_i,
	input  wire cache_tag_pkg::tag_write_t write_i,
	output      cache_tag_pkg::tag_entry_t [cache_tag_pkg::NUM_WAYS-1:0] entries_o,
	output      logic [cache_tag_pkg::NUM_WAYS-1:0]                       dirty_o
);

	for (genvar w = 0; w < cache_tag_pkg::NUM_WAYS; w++)
	begin : g_way
		logic way_sel;

		assign way_sel = write_i.way == cache_tag_pkg::way_t'(w);

		tag_sram #(
			.entry_t(cache_tag_pkg::tag_entry_t),
			.DEPTH(cache_tag_pkg::NUM_SETS)
		) tag_mem (
			.clk(clk),
			.reset(reset),
			.rd_en_i(rd_en_i),
			.rd_addr_i(rd_set_i),
			.wr_en_i(write_i.enable && way_sel),
			.wr_addr_i(write_i.set),
			.wr_data_i(write_i.entry),
			.rd_data_o(entries_o[w])
		);

		// Dirty bits have their own enable so a store hit can mark a line without a fill
		tag_sram #(
			.entry_t(logic),
			.DEPTH(cache_tag_pkg::NUM_SETS)
		) dirty_mem (
			.clk(clk),
			.reset(reset),
			.rd_en_i(rd_en_i),
			.rd_addr_i(rd_set_i),
			.wr_en_i(write_i.dirty_enable && way_sel),
			.wr_addr_i(write_i.set),
			.wr_data_i(write_i.dirty_value),
			.rd_data_o(dirty_o[w])
		);
	end

endmodule

`default_nettype wire

// File: src/tag_sram.sv
// One-read one-write memory with a registered read port, used for tag words and dirty bits
`default_nettype none

module tag_sram #(
	parameter type entry_t = logic,
	parameter int DEPTH = 16
) (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 rd_en_i,
	input  wire cache_tag_pkg::set_t  rd_addr_i,
	input  wire logic                 wr_en_i,
	input  wire cache_tag_pkg::set_t  wr_addr_i,
	input  wire entry_t               wr_data_i,
	output      entry_t               rd_data_o
);

	entry_t mem [DEPTH];

	// Every word starts out cleared so that all lines are invalid and clean
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
			rd_data_o <= '0;
		end
		else
		begin
			if (wr_en_i)
				mem[wr_addr_i] <= wr_data_i;
			if (rd_en_i)
				rd_data_o <= mem[rd_addr_i];
		end
	end

	// The lookup pipeline reads a set one cycle before it writes it back
	a_no_rw_collision: assert property (@(posedge clk) disable iff (reset)
		!(rd_en_i && wr_en_i && rd_addr_i == wr_addr_i))
		else $error("tag_sram read and write of the same address in one cycle");

endmodule

`default_nettype wire

// File: src/cache_tag_pkg.sv
// Shared geometry constants, address helpers and packed struct types for the cache tag subsystem
`default_nettype none

package cache_tag_pkg;

	localparam int NUM_WAYS = 4;
	localparam int WAY_BITS = 2;
	localparam int NUM_SETS = 16;
	localparam int SET_BITS = 4;
	localparam int TAG_BITS = 8;
	localparam int ADDR_BITS = 12;
	// Each set holds a root bit and one pair bit for each half of the ways
	localparam int LRU_BITS = 3;

	typedef logic [WAY_BITS-1:0] way_t;
	typedef logic [SET_BITS-1:0] set_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	// One word of a tag way memory
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		logic                 is_store;
		logic [ADDR_BITS-1:0] addr;
	} lookup_req_t;

	// The evict fields only carry information on a miss
	typedef struct packed {
		logic hit;
		way_t way;
		logic evict_valid;
		logic evict_dirty;
		tag_t evict_tag;
	} lookup_resp_t;

	typedef struct packed {
		logic       enable;
		set_t       set;
		way_t       way;
		tag_entry_t entry;
		logic       dirty_enable;
		logic       dirty_value;
	} tag_write_t;

	typedef struct packed {
		logic enable;
		set_t set;
		way_t way;
	} lru_update_t;

	// The tag is the upper part of the address, the set index the lower part
	function automatic tag_t addr_tag(logic [ADDR_BITS-1:0] addr);
		return addr[ADDR_BITS-1 -: TAG_BITS];
	endfunction

	function automatic set_t addr_set(logic [ADDR_BITS-1:0] addr);
		return addr[SET_BITS-1:0];
	endfunction

endpackage

`default_nettype wire
